//--- design/arith_unit.sv
// Three-stage arithmetic unit
// Operand capture, compute with carry and overflow, then flags and writeback

`default_nettype none

`include "exec_defines.svh"

module arith_unit
(
    input wire logic clk,
    input wire logic rst,

    input wire logic imm_en,
    input wire exec_pkg::reg_idx_t imm_dest,
    input wire exec_pkg::word_t imm_val,

    input wire logic op_en,
    input wire exec_pkg::au_op_t op,
    input wire exec_pkg::reg_idx_t op_dest,
    input wire exec_pkg::word_t src_a,
    input wire exec_pkg::word_t src_b,

    output logic wb_en,
    output exec_pkg::reg_idx_t wb_reg,
    output exec_pkg::word_t wb_data,

    output logic wb_flags_en,
    output exec_pkg::flags_t wb_flags
);
    import exec_pkg::*;

    // Valid bits per stage, register write and flags write
    logic [`EXEC_AU_LAT-1:0] vld;
    logic [`EXEC_AU_LAT-1:0] fvld;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            vld <= '0;
            fvld <= '0;
        end
        else
        begin
            vld <= {vld[`EXEC_AU_LAT-2:0], imm_en || op_en};
            fvld <= {fvld[`EXEC_AU_LAT-2:0], op_en};
        end
    end

    // Stage 1 input registers
    word_t s1_a;
    word_t s1_b;
    au_op_t s1_op;
    reg_idx_t s1_dest;

    always_ff @(posedge clk)
    begin
        // Immediate rides through as a + 0
        if (imm_en)
        begin
            s1_a <= imm_val;
            s1_b <= '0;
            s1_op <= op_add;
            s1_dest <= imm_dest;
        end
        else if (op_en)
        begin
            s1_a <= src_a;
            s1_b <= src_b;
            s1_op <= op;
            s1_dest <= op_dest;
        end
    end

    // Stage 2 compute
    logic [`EXEC_DATA_W:0] sum;
    logic [`EXEC_DATA_W:0] diff;
    word_t s2_res;
    logic s2_c;
    logic s2_v;
    reg_idx_t s2_dest;

    assign sum = {1'b0, s1_a} + {1'b0, s1_b};
    assign diff = {1'b0, s1_a} - {1'b0, s1_b};

    always_ff @(posedge clk)
    begin
        s2_dest <= s1_dest;
        s2_c <= 1'b0;
        s2_v <= 1'b0;
        case (s1_op)
            op_add:
            begin
                s2_res <= sum[`EXEC_DATA_W-1:0];
                s2_c <= sum[`EXEC_DATA_W];
                s2_v <= (s1_a[`EXEC_DATA_W-1] == s1_b[`EXEC_DATA_W-1]) &&
                        (sum[`EXEC_DATA_W-1] != s1_a[`EXEC_DATA_W-1]);
            end
            op_sub:
            begin
                s2_res <= diff[`EXEC_DATA_W-1:0];
                // Borrow
                s2_c <= diff[`EXEC_DATA_W];
                s2_v <= (s1_a[`EXEC_DATA_W-1] != s1_b[`EXEC_DATA_W-1]) &&
                        (diff[`EXEC_DATA_W-1] != s1_a[`EXEC_DATA_W-1]);
            end
            op_and: s2_res <= s1_a & s1_b;
            op_or:  s2_res <= s1_a | s1_b;
            op_xor: s2_res <= s1_a ^ s1_b;
            op_sll: s2_res <= s1_a << s1_b[4:0];
            op_srl: s2_res <= s1_a >> s1_b[4:0];
            default: s2_res <= word_t'($signed(s1_a) >>> s1_b[4:0]);
        endcase
    end

    // Stage 3 flags and writeback registers
    always_ff @(posedge clk)
    begin
        wb_reg <= s2_dest;
        wb_data <= s2_res;
        wb_flags <= {4'b0000, s2_v, s2_c, s2_res[`EXEC_DATA_W-1], s2_res == '0};
    end

    assign wb_en = vld[`EXEC_AU_LAT-1];
    assign wb_flags_en = fvld[`EXEC_AU_LAT-1];

    a_flags_with_reg: assert property (@(posedge clk) disable iff (rst) wb_flags_en |-> wb_en);

endmodule

`default_nettype wire

//--- design/exec_defines.svh
// Width, register count, pipeline depth and Wishbone address map
// for the execution block

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath widths
`define EXEC_DATA_W 32
`define EXEC_FLAGS_W 8
`define EXEC_IMM_W 24

// Register file
`define EXEC_NUM_REGS 8
`define EXEC_REG_IDX_W 3

// Arithmetic unit latency, issue to writeback
`define EXEC_AU_LAT 3

// Wishbone word addresses
`define EXEC_ADR_W 4
`define EXEC_ADR_INSN 4'd0
`define EXEC_ADR_STATUS 4'd1
`define EXEC_ADR_REG_BASE 4'd8

`endif

//--- design/exec_pkg.sv
// Shared types of the execution block
// Data word, register index, flags, ALU operation and issue FSM states

`default_nettype none

`include "exec_defines.svh"

package exec_pkg;

    typedef logic [`EXEC_DATA_W-1:0] word_t;
    typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;

    // Bit 0 zero, 1 negative, 2 carry, 3 overflow
    typedef logic [`EXEC_FLAGS_W-1:0] flags_t;

    // Encoding matches instruction bits 26:24
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_sra = 3'd7
    } au_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_hazard,
        st_ack
    } issue_state_t;

endpackage

`default_nettype wire

//--- design/exec_top.sv
// Execution block top level
// Issue control, arithmetic unit and register file

`default_nettype none

`include "exec_defines.svh"

module exec_top
(
    input wire logic clk,
    input wire logic rst,

    input wire logic cyc,
    input wire logic stb,
    input wire logic we,
    input wire logic [`EXEC_ADR_W-1:0] adr,
    input wire exec_pkg::word_t dat_w,
    output exec_pkg::word_t dat_r,
    output logic ack
);
    import exec_pkg::*;

    word_t reg0, reg1, reg2, reg3, reg4, reg5, reg6, reg7;
    flags_t flags;

    // Issue to arithmetic unit
    logic imm_en;
    reg_idx_t imm_dest;
    word_t imm_val;
    logic op_en;
    au_op_t op;
    reg_idx_t op_dest;
    word_t src_a;
    word_t src_b;

    // Writeback
    logic wb_en;
    reg_idx_t wb_reg;
    word_t wb_data;
    logic wb_flags_en;
    flags_t wb_flags;

    issue_ctrl issue_ctrl_i (
        .clk, .rst,
        .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .reg0, .reg1, .reg2, .reg3, .reg4, .reg5, .reg6, .reg7,
        .flags,
        .wb_en, .wb_reg, .wb_flags_en,
        .imm_en, .imm_dest, .imm_val,
        .op_en, .op, .op_dest, .src_a, .src_b
    );

    arith_unit arith_unit_i (
        .clk, .rst,
        .imm_en, .imm_dest, .imm_val,
        .op_en, .op, .op_dest, .src_a, .src_b,
        .wb_en, .wb_reg, .wb_data,
        .wb_flags_en, .wb_flags
    );

    reg_file reg_file_i (
        .clk, .rst,
        .wb_en, .wb_reg, .wb_data,
        .wb_flags_en, .wb_flags,
        .reg0, .reg1, .reg2, .reg3, .reg4, .reg5, .reg6, .reg7,
        .flags
    );

endmodule

`default_nettype wire

//--- design/issue_ctrl.sv
// Issue control for the execution block
// Wishbone classic slave, instruction decode, register scoreboard
// and register/status read multiplexing

`default_nettype none

`include "exec_defines.svh"

module issue_ctrl
(
    input wire logic clk,
    input wire logic rst,

    input wire logic cyc,
    input wire logic stb,
    input wire logic we,
    input wire logic [`EXEC_ADR_W-1:0] adr,
    input wire exec_pkg::word_t dat_w,
    output exec_pkg::word_t dat_r,
    output logic ack,

    input wire exec_pkg::word_t reg0,
    input wire exec_pkg::word_t reg1,
    input wire exec_pkg::word_t reg2,
    input wire exec_pkg::word_t reg3,
    input wire exec_pkg::word_t reg4,
    input wire exec_pkg::word_t reg5,
    input wire exec_pkg::word_t reg6,
    input wire exec_pkg::word_t reg7,
    input wire exec_pkg::flags_t flags,

    input wire logic wb_en,
    input wire exec_pkg::reg_idx_t wb_reg,
    input wire logic wb_flags_en,

    output logic imm_en,
    output exec_pkg::reg_idx_t imm_dest,
    output exec_pkg::word_t imm_val,

    output logic op_en,
    output exec_pkg::au_op_t op,
    output exec_pkg::reg_idx_t op_dest,
    output exec_pkg::word_t src_a,
    output exec_pkg::word_t src_b
);
    import exec_pkg::*;

    // Enough room for every flags write the pipeline can hold
    localparam int FCNT_W = $clog2(`EXEC_AU_LAT + 1);

    issue_state_t state;
    word_t regs [`EXEC_NUM_REGS];
    logic [`EXEC_NUM_REGS-1:0] pending;
    logic [`EXEC_NUM_REGS-1:0] pend_set;
    logic [`EXEC_NUM_REGS-1:0] pend_clr;
    logic [FCNT_W-1:0] flags_cnt;
    logic flags_busy;

    assign regs[0] = reg0;
    assign regs[1] = reg1;
    assign regs[2] = reg2;
    assign regs[3] = reg3;
    assign regs[4] = reg4;
    assign regs[5] = reg5;
    assign regs[6] = reg6;
    assign regs[7] = reg7;

    // Instruction fields
    logic is_imm;
    reg_idx_t dest;
    reg_idx_t sel_a;
    reg_idx_t sel_b;
    reg_idx_t rd_idx;

    assign is_imm = dat_w[31];
    assign dest = dat_w[30:28];
    assign sel_a = dat_w[22:20];
    assign sel_b = dat_w[18:16];
    assign rd_idx = reg_idx_t'(adr - `EXEC_ADR_REG_BASE);

    // Access type of the current request
    logic req;
    logic insn_wr;
    logic reg_rd;
    logic stat_rd;
    logic hazard;
    logic accept;

    assign req = cyc && stb;
    assign insn_wr = we && (adr == `EXEC_ADR_INSN);
    assign reg_rd = !we && (adr >= `EXEC_ADR_REG_BASE);
    assign stat_rd = !we && (adr == `EXEC_ADR_STATUS);
    assign flags_busy = (flags_cnt != '0);

    // Operands and destination must not have a write outstanding
    always_comb
    begin
        if (insn_wr)
            hazard = pending[dest] || (!is_imm && (pending[sel_a] || pending[sel_b]));
        else if (reg_rd)
            hazard = pending[rd_idx];
        else if (stat_rd)
            hazard = flags_busy;
        else
            hazard = 1'b0;
    end

    assign accept = req && !hazard && (state != st_ack);
    assign ack = (state == st_ack);

    assign pend_set = (accept && insn_wr) ? (`EXEC_NUM_REGS'(1) << dest) : '0;
    assign pend_clr = wb_en ? (`EXEC_NUM_REGS'(1) << wb_reg) : '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= st_idle;
            imm_en <= 1'b0;
            op_en <= 1'b0;
            pending <= '0;
            flags_cnt <= '0;
        end
        else
        begin
            case (state)
                st_idle, st_wait_hazard:
                    if (!req)
                        state <= st_idle;
                    else if (hazard)
                        state <= st_wait_hazard;
                    else
                        state <= st_ack;
                default:
                    state <= st_idle;
            endcase

            imm_en <= accept && insn_wr && is_imm;
            op_en <= accept && insn_wr && !is_imm;
            pending <= (pending & ~pend_clr) | pend_set;

            // Issue and writeback of flags may land on the same edge
            if ((accept && insn_wr && !is_imm) && !wb_flags_en)
                flags_cnt <= flags_cnt + 1'b1;
            else if (!(accept && insn_wr && !is_imm) && wb_flags_en)
                flags_cnt <= flags_cnt - 1'b1;
        end
    end

    // Issue payload and read data, captured on acceptance
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            imm_dest <= dest;
            imm_val <= {{(`EXEC_DATA_W - `EXEC_IMM_W){dat_w[`EXEC_IMM_W-1]}},
                        dat_w[`EXEC_IMM_W-1:0]};
            op <= au_op_t'(dat_w[26:24]);
            op_dest <= dest;
            src_a <= regs[sel_a];
            src_b <= regs[sel_b];

            if (reg_rd)
                dat_r <= regs[rd_idx];
            else if (stat_rd)
                dat_r <= word_t'({(pending != '0) || flags_busy, flags});
            else
                dat_r <= '0;
        end
    end

    a_one_issue: assert property (@(posedge clk) disable iff (rst) !(imm_en && op_en));
    a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

`default_nettype wire

//--- design/reg_file.sv
// Architectural state of the execution block
// Eight data registers and the flags register, one write port

`default_nettype none

`include "exec_defines.svh"

module reg_file
(
    input wire logic clk,
    input wire logic rst,

    input wire logic wb_en,
    input wire exec_pkg::reg_idx_t wb_reg,
    input wire exec_pkg::word_t wb_data,
    input wire logic wb_flags_en,
    input wire exec_pkg::flags_t wb_flags,

    output exec_pkg::word_t reg0,
    output exec_pkg::word_t reg1,
    output exec_pkg::word_t reg2,
    output exec_pkg::word_t reg3,
    output exec_pkg::word_t reg4,
    output exec_pkg::word_t reg5,
    output exec_pkg::word_t reg6,
    output exec_pkg::word_t reg7,
    output exec_pkg::flags_t flags
);
    import exec_pkg::*;

    word_t regs [`EXEC_NUM_REGS];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `EXEC_NUM_REGS; i++)
                regs[i] <= '0;
            flags <= '0;
        end
        else
        begin
            if (wb_en)
                regs[wb_reg] <= wb_data;
            if (wb_flags_en)
                flags <= wb_flags;
        end
    end

    assign reg0 = regs[0];
    assign reg1 = regs[1];
    assign reg2 = regs[2];
    assign reg3 = regs[3];
    assign reg4 = regs[4];
    assign reg5 = regs[5];
    assign reg6 = regs[6];
    assign reg7 = regs[7];

endmodule

`default_nettype wire

//--- dv/exec_tb.sv
// Testbench for the execution block
// Clock and reset, LFSR stimulus, Wishbone master tasks, register and flags model,
// value check task and watchdog

`default_nettype none

`include "exec_defines.svh"

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int IMM_SINGLES = 8;
    localparam int ALU_ROUNDS = 40;
    localparam int CHAINS = 6;
    localparam int CHAIN_LEN = 4;
    localparam int JUNK_WRITES = 8;
    // Upper bound on bus transactions over all phases
    localparam int MAX_TRANS = 9 + (16 + 3 * IMM_SINGLES) + 6 * ALU_ROUNDS
                               + CHAINS * (CHAIN_LEN + 9) + (JUNK_WRITES + 6 + 9);
    localparam int CYCLES_PER_TRANS = 20;

    logic clk;
    logic rst;
    logic cyc;
    logic stb;
    logic we;
    logic [`EXEC_ADR_W-1:0] adr;
    word_t dat_w;
    word_t dat_r;
    logic ack;

    word_t model_regs [`EXEC_NUM_REGS];
    flags_t model_flags;
    logic [31:0] lfsr_state;
    int checks;
    int errors;

    exec_top exec_top_i (
        .clk, .rst,
        .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Reference ALU with flags
    function automatic void alu_model(input logic [2:0] code, input word_t a, input word_t b,
                                      output word_t res, output flags_t fl);
        logic [32:0] swide;
        logic c;
        logic v;
        c = 1'b0;
        v = 1'b0;
        swide = '0;
        case (code)
            3'd0:
            begin
                res = a + b;
                // Carry out when the unsigned sum wraps
                c = (res < a);
                swide = {a[31], a} + {b[31], b};
                v = (swide[32] != swide[31]);
            end
            3'd1:
            begin
                res = a - b;
                // Borrow
                c = (a < b);
                swide = {a[31], a} - {b[31], b};
                v = (swide[32] != swide[31]);
            end
            3'd2: res = a & b;
            3'd3: res = a | b;
            3'd4: res = a ^ b;
            3'd5: res = a << b[4:0];
            3'd6: res = a >> b[4:0];
            default:
            begin
                // Vacated upper bits take the sign
                res = a >> b[4:0];
                if (a[31])
                    res = res | ~(32'hffff_ffff >> b[4:0]);
            end
        endcase
        fl = {4'b0000, v, c, res[31], res == 32'd0};
    endfunction

    task automatic check_value(input word_t expected, input word_t actual, input string what);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("error @%0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [`EXEC_ADR_W-1:0] addr,
                             input word_t wdata, output word_t rdata);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= write;
        adr <= addr;
        dat_w <= wdata;
        // Ack and read data are sampled mid-cycle
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic idle_gap();
        repeat (take_bits(2)) @(posedge clk);
    endtask

    task automatic load_imm(input reg_idx_t dest);
        word_t insn;
        word_t unused;
        // Ignored bits stay random
        insn = take_bits(32);
        insn[31] = 1'b1;
        insn[30:28] = dest;
        bus_cycle(1'b1, `EXEC_ADR_INSN, insn, unused);
        model_regs[dest] = {{8{insn[23]}}, insn[23:0]};
    endtask

    task automatic issue_alu(input logic [2:0] code, input reg_idx_t dest,
                             input reg_idx_t sa, input reg_idx_t sb);
        word_t insn;
        word_t unused;
        word_t res;
        flags_t fl;
        insn = take_bits(32);
        insn[31] = 1'b0;
        insn[30:28] = dest;
        insn[26:24] = code;
        insn[22:20] = sa;
        insn[18:16] = sb;
        bus_cycle(1'b1, `EXEC_ADR_INSN, insn, unused);
        alu_model(code, model_regs[sa], model_regs[sb], res, fl);
        model_regs[dest] = res;
        model_flags = fl;
    endtask

    task automatic read_reg(input reg_idx_t idx);
        word_t data;
        bus_cycle(1'b0, {1'b0, idx} + `EXEC_ADR_REG_BASE, '0, data);
        check_value(model_regs[idx], data, $sformatf("register %0d", idx));
    endtask

    // Expects busy low
    task automatic read_status();
        word_t data;
        bus_cycle(1'b0, `EXEC_ADR_STATUS, '0, data);
        check_value({24'd0, model_flags}, data, "status");
    endtask

    task automatic read_all();
        for (int i = 0; i < `EXEC_NUM_REGS; i++)
            read_reg(reg_idx_t'(i));
        read_status();
    endtask

    task automatic after_reset_reads();
        read_all();
    endtask

    task automatic imm_loads();
        reg_idx_t dest;
        // Back-to-back loads to every register
        for (int i = 0; i < `EXEC_NUM_REGS; i++)
            load_imm(reg_idx_t'(i));
        for (int i = 0; i < `EXEC_NUM_REGS; i++)
            read_reg(reg_idx_t'(i));
        for (int i = 0; i < IMM_SINGLES; i++)
        begin
            dest = reg_idx_t'(take_bits(3));
            load_imm(dest);
            read_reg(dest);
            read_status();
            idle_gap();
        end
    endtask

    task automatic alu_ops();
        reg_idx_t dest;
        reg_idx_t refill;
        for (int i = 0; i < ALU_ROUNDS; i++)
        begin
            // Occasional fresh operand that must leave the flags alone
            if (take_bits(2) == 0)
            begin
                refill = reg_idx_t'(take_bits(3));
                load_imm(refill);
                read_reg(refill);
                read_status();
            end
            dest = reg_idx_t'(take_bits(3));
            issue_alu(3'(i), dest, reg_idx_t'(take_bits(3)), reg_idx_t'(take_bits(3)));
            // Status read waits for the flags writeback
            read_status();
            read_reg(dest);
            idle_gap();
        end
    endtask

    task automatic dependent_chains();
        reg_idx_t prev;
        reg_idx_t dest;
        for (int c = 0; c < CHAINS; c++)
        begin
            prev = reg_idx_t'(take_bits(3));
            for (int k = 0; k < CHAIN_LEN; k++)
            begin
                dest = reg_idx_t'(take_bits(3));
                issue_alu(3'(take_bits(3)), dest, prev, reg_idx_t'(take_bits(3)));
                prev = dest;
            end
            read_all();
        end
    endtask

    task automatic unused_writes();
        logic [`EXEC_ADR_W-1:0] addr;
        word_t data;
        for (int i = 0; i < JUNK_WRITES; i++)
        begin
            addr = `EXEC_ADR_W'(take_bits(`EXEC_ADR_W));
            if (addr == `EXEC_ADR_INSN)
                addr = `EXEC_ADR_STATUS;
            bus_cycle(1'b1, addr, take_bits(32), data);
        end
        // Holes in the map read as zero
        for (int a = 2; a < 8; a++)
        begin
            bus_cycle(1'b0, `EXEC_ADR_W'(a), '0, data);
            check_value('0, data, $sformatf("unused address %0d", a));
        end
        read_all();
    endtask

    initial
    begin
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        rst = 1'b1;
        lfsr_state = 32'h426c;
        checks = 0;
        errors = 0;
        for (int i = 0; i < `EXEC_NUM_REGS; i++)
            model_regs[i] = '0;
        model_flags = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        after_reset_reads();
        imm_loads();
        alu_ops();
        dependent_chains();
        unused_writes();

        @(posedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #(CLK_PERIOD * (MAX_TRANS * CYCLES_PER_TRANS + RESET_CYCLES));
        $display("Timeout: the bus stopped acknowledging before all tests were done");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/exec_pkg.sv
design/arith_unit.sv
design/reg_file.sv
design/issue_ctrl.sv
design/exec_top.sv
dv/exec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execution block testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module exec_tb \
    -o exec_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/exec_sim 2>&1 | tee sim.log

grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
